// ==== design/cs_consts.svh ====
/*
  sizes of the writable control store.
  the control logic decodes exactly four slices, so CS_SLICES stays at 4.
  CS_DEPTH must equal 2**CS_ADDR_W.
*/

`ifndef CS_CONSTS_SVH
`define CS_CONSTS_SVH

// microword address width.
`define CS_ADDR_W  8

// microwords held in the store.
`define CS_DEPTH   256

// one cpu data bus word, and one microword slice.
`define CS_SLICE_W 16

// slices per microword, fixed by the 2-to-4 decoders.
`define CS_SLICES  4

`endif

// ==== design/cs_pkg.sv ====
/*
  shared types for the control store.
  widths come from the constants header.
  the microword keeps slice 0 in its low bits.
*/

`include "cs_consts.svh"

`default_nettype none

package cs_pkg;

  // microword address.
  typedef logic [`CS_ADDR_W-1:0] cs_addr_t;

  // data bus word, and one slice of a microword.
  typedef logic [`CS_SLICE_W-1:0] cs_slice_t;

  // rf field, picks one slice.
  typedef logic [$clog2(`CS_SLICES)-1:0] cs_sel_t;

  // active-low strobes, one bit per slice.
  typedef logic [`CS_SLICES-1:0] cs_strobe_t;

  // full microword, slice 3 on top.
  typedef logic [`CS_SLICES*`CS_SLICE_W-1:0] cs_uword_t;

  // request fsm of the control block.
  typedef enum logic [1:0] {
    CS_IDLE = 2'd0,
    CS_WSTB = 2'd1,
    CS_RDEN = 2'd2
  } cs_ctl_state_t;

endpackage

`default_nettype wire

// ==== design/cs_ctl_if.sv ====
/*
  strobes and enables from the control block to the store.
  everything here is driven by the control side.
  all strobes and enables are active low.
*/

`timescale 1ns/1ps
`default_nettype none

interface cs_ctl_if import cs_pkg::*; ();

  // slice write strobes, at most one low.
  cs_strobe_t ww_n;
  // slice readback enables, at most one low.
  cs_strobe_t ew_n;
  // latch half enables and control store latch enable.
  logic       eupp_n;
  logic       elow_n;
  logic       ecsl_n;
  // request payload, held for the strobe cycle.
  cs_addr_t   addr;
  cs_slice_t  wdata;

  modport ctl (
    output ww_n, ew_n, eupp_n, elow_n, ecsl_n, addr, wdata
  );

  modport store (
    input ww_n, ew_n, eupp_n, elow_n, ecsl_n, addr, wdata
  );

endinterface

`default_nettype wire

// ==== design/cs_ctl.sv ====
/*
  control store control. one request per idle cycle, one strobe cycle.
  requests are single-cycle and active low except fetch.
  priority on collision is load, then read, then fetch.
  a request that arrives while busy is dropped, with no back-pressure.
  term_n low in the strobe cycle kills the write strobe.
*/

`timescale 1ns/1ps
`default_nettype none

module cs_ctl import cs_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      lcs_n,
  input  logic      rwcs_n,
  input  logic      fetch,
  input  logic      brk_n,
  input  logic      term_n,
  input  cs_sel_t   rf,
  input  cs_addr_t  addr,
  input  cs_slice_t data_in,
  cs_ctl_if.ctl     bus
);

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  cs_ctl_state_t state_q;
  cs_ctl_state_t state_d;
  logic          fetch_q;
  logic          idle;
  logic          ld_req;
  logic          rd_req;
  logic          fe_req;
  logic          wstb_en;
  logic          rden_en;
  cs_sel_t       rf_q;
  cs_addr_t      addr_q;
  cs_slice_t     wdata_q;

  // a fetch in flight also counts as busy.
  assign idle = (state_q == CS_IDLE) && !fetch_q;

  // fixed priority, only one request wins.
  assign ld_req = idle && !lcs_n;
  assign rd_req = idle && lcs_n && !rwcs_n;
  // break freezes the latch, so fetch is ignored.
  assign fe_req = idle && lcs_n && rwcs_n && fetch && brk_n;

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      CS_IDLE: begin
        if (ld_req) begin
          state_d = CS_WSTB;
        end else if (rd_req) begin
          state_d = CS_RDEN;
        end
      end
      // strobe and enable cycles last one clock.
      CS_WSTB: state_d = CS_IDLE;
      CS_RDEN: state_d = CS_IDLE;
      default: state_d = CS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= CS_IDLE;
      fetch_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // fetch runs beside the fsm as a one-cycle flag.
      fetch_q <= fe_req;
    end
  end

  // request payload, taken with the winning request.
  always_ff @(posedge clk) begin
    if (ld_req || rd_req || fe_req) begin
      rf_q   <= rf;
      addr_q <= addr;
    end
    if (ld_req) begin
      wdata_q <= data_in;
    end
  end

  ////////////////////////////////////////
  // 2-to-4 decoders
  ////////////////////////////////////////

  // one half of a '139, low output picked by sel while enabled.
  function automatic cs_strobe_t dec_2to4_n(input cs_sel_t sel, input logic en);
    cs_strobe_t y;
    y = 4'b1111;
    if (en) begin
      case (sel)
        2'd0:    y = 4'b1110;
        2'd1:    y = 4'b1101;
        2'd2:    y = 4'b1011;
        default: y = 4'b0111;
      endcase
    end
    return y;
  endfunction

  // terminate arrives during the strobe cycle itself.
  assign wstb_en = (state_q == CS_WSTB) && term_n;
  assign rden_en = (state_q == CS_RDEN);

  assign bus.ww_n   = dec_2to4_n(rf_q, wstb_en);
  assign bus.ew_n   = dec_2to4_n(rf_q, rden_en);
  // whole microword is latched, both halves together.
  assign bus.ecsl_n = !fetch_q;
  assign bus.eupp_n = !fetch_q;
  assign bus.elow_n = !fetch_q;
  assign bus.addr   = addr_q;
  assign bus.wdata  = wdata_q;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_ww_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(~bus.ww_n)
  );

  // readback never overlaps a write strobe.
  a_ww_ew_excl: assert property (
    @(posedge clk) disable iff (!rst_n) (&bus.ww_n) || (&bus.ew_n)
  );

endmodule

`default_nettype wire

// ==== design/cs_store.sv ====
/*
  microword memory, readback register and microword latch.
  the array read is registered once like a sync ram, then
  data_out and uword register one clock later.
  read and fetch results appear two edges after the request.
  memory contents are undefined until written.
*/

`include "cs_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module cs_store import cs_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  cs_ctl_if.store   bus,
  output cs_slice_t data_out,
  output logic      data_valid,
  output cs_uword_t uword
);

  localparam int HALF_W = `CS_SLICES * `CS_SLICE_W / 2;

  cs_slice_t         rd_slice [`CS_SLICES];
  cs_slice_t         rb_mux;
  logic              rb_hit;
  cs_slice_t         rb_q;
  logic              rb_pend;
  logic [HALF_W-1:0] upp_q;
  logic [HALF_W-1:0] low_q;
  logic              upp_ld;
  logic              low_ld;

  ////////////////////////////////////////
  // slice arrays
  ////////////////////////////////////////

  for (genvar g = 0; g < `CS_SLICES; g++) begin : g_slice
    cs_slice_t mem [`CS_DEPTH];

    // write lands on the edge ending the strobe cycle.
    always_ff @(posedge clk) begin
      if (!bus.ww_n[g]) begin
        mem[bus.addr] <= bus.wdata;
      end
    end

    assign rd_slice[g] = mem[bus.addr];
  end

  ////////////////////////////////////////
  // readback path
  ////////////////////////////////////////

  // select the slice whose enable is low.
  always_comb begin
    rb_mux = '0;
    for (int i = 0; i < `CS_SLICES; i++) begin
      if (!bus.ew_n[i]) begin
        rb_mux = rd_slice[i];
      end
    end
  end

  assign rb_hit = ~&bus.ew_n;

  // first stage, read port register.
  always_ff @(posedge clk) begin
    if (rb_hit) begin
      rb_q <= rb_mux;
    end
    // halves load only under the latch enable.
    if (!bus.ecsl_n && !bus.eupp_n) begin
      upp_q <= {rd_slice[3], rd_slice[2]};
    end
    if (!bus.ecsl_n && !bus.elow_n) begin
      low_q <= {rd_slice[1], rd_slice[0]};
    end
  end

  // second stage, drives the readback slice.
  always_ff @(posedge clk) begin
    if (rb_pend) begin
      data_out <= rb_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rb_pend    <= 1'b0;
      upp_ld     <= 1'b0;
      low_ld     <= 1'b0;
      data_valid <= 1'b0;
      uword      <= '0;
    end else begin
      rb_pend    <= rb_hit;
      upp_ld     <= !bus.ecsl_n && !bus.eupp_n;
      low_ld     <= !bus.ecsl_n && !bus.elow_n;
      data_valid <= rb_pend;
      // uword holds between fetches.
      if (upp_ld) begin
        uword[2*HALF_W-1:HALF_W] <= upp_q;
      end
      if (low_ld) begin
        uword[HALF_W-1:0] <= low_q;
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_ew_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(~bus.ew_n)
  );

endmodule

`default_nettype wire

// ==== design/cs_top.sv ====
/*
  writable control store, control block plus store.
  one request at a time, spaced so the previous one has finished.
  fetch is ignored while brk_n is low.
  read data and the microword arrive two clocks after the request edge.
*/

`timescale 1ns/1ps
`default_nettype none

module cs_top import cs_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // load control store, one-cycle low.
  input  logic      lcs_n,
  // read control store, one-cycle low.
  input  logic      rwcs_n,
  // microword fetch, one-cycle high.
  input  logic      fetch,
  // break, level.
  input  logic      brk_n,
  // terminate, cancels a pending write.
  input  logic      term_n,
  input  cs_sel_t   rf,
  input  cs_addr_t  addr,
  input  cs_slice_t data_in,
  output cs_slice_t data_out,
  output logic      data_valid,
  output cs_uword_t uword
);

  ////////////////////////////////////////
  // control to store bus
  ////////////////////////////////////////

  cs_ctl_if bus ();

  ////////////////////////////////////////
  // control block
  ////////////////////////////////////////

  // request fsm and strobe decoders.
  cs_ctl u_ctl (
    .clk     (clk),
    .rst_n   (rst_n),
    .lcs_n   (lcs_n),
    .rwcs_n  (rwcs_n),
    .fetch   (fetch),
    .brk_n   (brk_n),
    .term_n  (term_n),
    .rf      (rf),
    .addr    (addr),
    .data_in (data_in),
    .bus     (bus)
  );

  ////////////////////////////////////////
  // store
  ////////////////////////////////////////

  // slice arrays, readback register and latch.
  cs_store u_store (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (bus),
    .data_out   (data_out),
    .data_valid (data_valid),
    .uword      (uword)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
/*
  clock and reset for the control store testbench.
  40 ns clock, reset held low over the first three rising edges.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  // free running clock, 20 ns per phase.
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // release on the third rising edge.
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== dv/tb_cs.sv ====
/*
  testbench for the writable control store.
  requests are spaced four cycles apart, so every request is accepted.
  reads and fetches are checked three falling edges after the request is seen.
  the model starts as X, so only written slices are read back or fetched.
*/

`include "cs_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module tb_cs import cs_pkg::*; ();

  localparam int OP_CYC    = 4;
  localparam int DRAIN_CYC = 4;
  localparam int NUM_TESTS = 6;
  // write/read pairs, full words, break, terminate, slice isolation.
  localparam int TOTAL_OPS = 128 + 80 + 2 + 4 + 5;
  localparam int RUN_CYC   = TOTAL_OPS * OP_CYC + NUM_TESTS * (DRAIN_CYC + 4) + 8;
  localparam int MAX_CYC   = 2 * RUN_CYC;
  // request seen on one falling edge, result on the third one after.
  localparam int RESP_LAT  = 3;

  logic        clk;
  logic        rst_n;
  logic        lcs_n;
  logic        rwcs_n;
  logic        fetch;
  logic        brk_n;
  logic        term_n;
  cs_sel_t     rf;
  cs_addr_t    addr;
  cs_slice_t   data_in;
  cs_slice_t   data_out;
  logic        data_valid;
  cs_uword_t   uword;

  logic [31:0] lfsr;
  cs_uword_t   ref_mem [`CS_DEPTH];
  cs_uword_t   latch_model;
  cs_addr_t    full_addr [16];
  int          errors = 0;
  int          tests_run = 0;
  int          tests_passed = 0;
  int          cyc = 0;
  int          ncyc = 0;
  // pending results, due falling edge and expected value.
  int          rd_due [$];
  cs_slice_t   rd_exp [$];
  int          fe_due [$];
  cs_uword_t   fe_exp [$];

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cs_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .lcs_n      (lcs_n),
    .rwcs_n     (rwcs_n),
    .fetch      (fetch),
    .brk_n      (brk_n),
    .term_n     (term_n),
    .rf         (rf),
    .addr       (addr),
    .data_in    (data_in),
    .data_out   (data_out),
    .data_valid (data_valid),
    .uword      (uword)
  );

  ////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////

  // right shifting galois lfsr, taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one lfsr step per bit taken.
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic cs_slice_t ref_slice(input cs_addr_t a, input cs_sel_t sel);
    return ref_mem[a][int'(sel)*`CS_SLICE_W +: `CS_SLICE_W];
  endfunction

  // slice 0 sits in the low bits.
  function automatic cs_uword_t ref_uword(input cs_addr_t a);
    return {ref_slice(a, 2'd3), ref_slice(a, 2'd2), ref_slice(a, 2'd1), ref_slice(a, 2'd0)};
  endfunction

  task automatic report_mismatch(input string what, input cs_uword_t got, input cs_uword_t exp);
    $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("failure at %0t ns: %s", $time, msg);
    errors++;
  endtask

  ////////////////////////////////////////
  // request drivers
  ////////////////////////////////////////

  // load request, term_n low in the strobe cycle when cancelled.
  task automatic write_slice(input cs_addr_t a, input cs_sel_t sel, input cs_slice_t d,
                             input logic cancel);
    @(posedge clk);
    lcs_n   <= 1'b0;
    addr    <= a;
    rf      <= sel;
    data_in <= d;
    @(posedge clk);
    lcs_n  <= 1'b1;
    term_n <= !cancel;
    if (!cancel) begin
      ref_mem[a][int'(sel)*`CS_SLICE_W +: `CS_SLICE_W] = d;
    end
    @(posedge clk);
    term_n <= 1'b1;
    @(posedge clk);
  endtask

  task automatic read_slice(input cs_addr_t a, input cs_sel_t sel);
    @(posedge clk);
    rwcs_n <= 1'b0;
    addr   <= a;
    rf     <= sel;
    @(posedge clk);
    rwcs_n <= 1'b1;
    repeat (2) @(posedge clk);
  endtask

  task automatic fetch_word(input cs_addr_t a);
    @(posedge clk);
    fetch <= 1'b1;
    addr  <= a;
    @(posedge clk);
    fetch <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////

  always @(negedge clk) begin : compare
    cs_slice_t exp_s;
    cs_uword_t exp_w;
    ncyc++;
    if (rst_n === 1'b1) begin
      if (rd_due.size() > 0 && rd_due[0] == ncyc) begin
        exp_s = rd_exp.pop_front();
        void'(rd_due.pop_front());
        if (data_valid !== 1'b1) begin
          report_failure("read request got no data_valid pulse two cycles later");
        end else if (data_out !== exp_s) begin
          report_mismatch("readback data_out", cs_uword_t'(data_out), cs_uword_t'(exp_s));
        end
      end else if (data_valid !== 1'b0) begin
        report_failure("data_valid was high with no read pending");
      end
      if (fe_due.size() > 0 && fe_due[0] == ncyc) begin
        exp_w = fe_exp.pop_front();
        void'(fe_due.pop_front());
        latch_model = exp_w;
        if (uword !== exp_w) begin
          report_mismatch("fetched uword", uword, exp_w);
        end
      end
      // requests sampled on the next rising edge, lcs_n wins.
      if (lcs_n === 1'b1 && rwcs_n === 1'b0) begin
        rd_due.push_back(ncyc + RESP_LAT);
        rd_exp.push_back(ref_slice(addr, rf));
      end else if (lcs_n === 1'b1 && rwcs_n === 1'b1 && fetch === 1'b1 && brk_n === 1'b1) begin
        fe_due.push_back(ncyc + RESP_LAT);
        fe_exp.push_back(ref_uword(addr));
      end
    end
  end

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic check_reset_state();
    @(negedge clk);
    if (data_valid !== 1'b0) begin
      report_mismatch("data_valid after reset", cs_uword_t'(data_valid), '0);
    end
    if (uword !== '0) begin
      report_mismatch("uword after reset", uword, '0);
    end
    latch_model = '0;
  endtask

  task automatic write_read_random();
    logic [31:0] r;
    cs_addr_t    a;
    cs_sel_t     s;
    for (int i = 0; i < 64; i++) begin
      rand_bits(`CS_ADDR_W, r);
      a = r[`CS_ADDR_W-1:0];
      rand_bits(2, r);
      s = r[1:0];
      rand_bits(`CS_SLICE_W, r);
      write_slice(a, s, r[`CS_SLICE_W-1:0], 1'b0);
      read_slice(a, s);
    end
  endtask

  task automatic fetch_full_words();
    logic [31:0] r;
    for (int i = 0; i < 16; i++) begin
      rand_bits(`CS_ADDR_W, r);
      full_addr[i] = r[`CS_ADDR_W-1:0];
      for (int s = 0; s < `CS_SLICES; s++) begin
        rand_bits(`CS_SLICE_W, r);
        write_slice(full_addr[i], cs_sel_t'(s), r[`CS_SLICE_W-1:0], 1'b0);
      end
    end
    for (int i = 0; i < 16; i++) begin
      fetch_word(full_addr[i]);
    end
  endtask

  task automatic break_holds_latch();
    cs_uword_t held;
    int        pick;
    held = latch_model;
    pick = 0;
    // a word that differs from the latch, so a wrong load shows.
    for (int i = 15; i >= 0; i--) begin
      if (ref_uword(full_addr[i]) !== held) begin
        pick = i;
      end
    end
    @(posedge clk);
    brk_n <= 1'b0;
    fetch_word(full_addr[pick]);
    @(negedge clk);
    if (uword !== held) begin
      report_mismatch("uword during break", uword, held);
    end
    @(posedge clk);
    brk_n <= 1'b1;
    fetch_word(full_addr[pick]);
  endtask

  task automatic term_cancels_write();
    logic [31:0] r;
    cs_addr_t    a;
    cs_sel_t     s;
    cs_slice_t   old;
    a = full_addr[2];
    rand_bits(2, r);
    s = r[1:0];
    old = ref_slice(a, s);
    write_slice(a, s, ~old, 1'b1);
    read_slice(a, s);
    // a plain load afterwards still lands.
    write_slice(a, s, ~old, 1'b0);
    read_slice(a, s);
  endtask

  task automatic slice_isolation();
    logic [31:0] r;
    cs_addr_t    a;
    cs_sel_t     s;
    a = full_addr[3];
    rand_bits(2, r);
    s = r[1:0];
    rand_bits(`CS_SLICE_W, r);
    write_slice(a, s, r[`CS_SLICE_W-1:0], 1'b0);
    for (int k = 0; k < `CS_SLICES; k++) begin
      if (cs_sel_t'(k) != s) begin
        read_slice(a, cs_sel_t'(k));
      end
    end
    fetch_word(a);
  endtask

  // let pending results drain, then one line per test.
  task automatic close_test(input string name, input int err_before);
    repeat (DRAIN_CYC) @(posedge clk);
    tests_run++;
    if (errors == err_before) begin
      tests_passed++;
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial begin : main
    int err_before;
    lcs_n   = 1'b1;
    rwcs_n  = 1'b1;
    fetch   = 1'b0;
    brk_n   = 1'b1;
    term_n  = 1'b1;
    rf      = '0;
    addr    = '0;
    data_in = '0;
    lfsr    = 32'h10fd_9972;
    wait (rst_n === 1'b1);
    err_before = errors;
    check_reset_state();
    close_test("reset state", err_before);
    err_before = errors;
    write_read_random();
    close_test("random write and readback", err_before);
    err_before = errors;
    fetch_full_words();
    close_test("full microword fetch", err_before);
    err_before = errors;
    break_holds_latch();
    close_test("break holds latch", err_before);
    err_before = errors;
    term_cancels_write();
    close_test("terminate cancels write", err_before);
    err_before = errors;
    slice_isolation();
    close_test("slice isolation", err_before);
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_passed, tests_run - tests_passed, errors);
    if (errors == 0 && tests_passed == NUM_TESTS) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // ends a stuck run at twice the expected length.
  initial begin : watchdog
    while (cyc < MAX_CYC) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", MAX_CYC);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/cs_pkg.sv
design/cs_ctl_if.sv
design/cs_ctl.sv
design/cs_store.sv
design/cs_top.sv
dv/tb_clkgen.sv
dv/tb_cs.sv

// ==== Makefile ====
# Verilator build and run for the control store testbench.

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_cs
FILELIST  := files.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output.
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
